//--- include/serdes_settings.svh
`ifndef SERDES_SETTINGS_SVH
`define SERDES_SETTINGS_SVH

// bits per parallel word on the lane
`define SERDES_WORD_W 8

// lock thresholds, counted in received words
`define SERDES_LOCK_GOOD 4
`define SERDES_LOCK_BAD 4
// unlocked words before the checker slips one bit
`define SERDES_SLIP_WORDS 16

// APB register byte offsets
`define SERDES_ADDR_CTRL 8'h00
`define SERDES_ADDR_STATUS 8'h04
`define SERDES_ADDR_ERRCNT 8'h08
`define SERDES_ADDR_SLIPCNT 8'h0C

`endif

//--- logic/serdes_pkg.sv
`include "serdes_settings.svh"

package serdes_pkg;

    typedef logic [`SERDES_WORD_W-1:0] serdes_word_t;
    typedef logic [15:0] serdes_cnt_t;
    // PRBS-7 shift state
    typedef logic [6:0] prbs_state_t;
    // counts bit positions inside one word
    typedef logic [$clog2(`SERDES_WORD_W)-1:0] bit_cnt_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic enable;
        logic inject_err;
        logic clear_cnt;
    } link_ctrl_t;

    typedef struct packed {
        logic        locked;
        serdes_cnt_t err_cnt;
        serdes_cnt_t slip_cnt;
    } link_stat_t;

    typedef enum logic [1:0] {SEARCH, VERIFY, LOCKED} chk_state_e;

    // next word of x^7+x^6+1, first bit in the msb
    // with 7 or more bits per word the new state is the low 7 bits
    function automatic serdes_word_t prbs_word(input prbs_state_t seed);
        prbs_state_t  s;
        serdes_word_t w;
        s = seed;
        for (int i = `SERDES_WORD_W - 1; i >= 0; i--) begin
            w[i] = s[6] ^ s[5];
            s = {s[5:0], w[i]};
        end
        return w;
    endfunction

endpackage

//--- logic/serdes_regs.sv
`timescale 1ns/1ps
`include "serdes_settings.svh"

module serdes_regs (
    input  logic                   CLKDIV,
    input  logic                   RST,
    input  serdes_pkg::apb_req_t   apb_req,
    output serdes_pkg::apb_rsp_t   apb_rsp,
    output serdes_pkg::link_ctrl_t link_ctrl,
    input  serdes_pkg::link_stat_t link_stat,
    output logic                   lane_rst,
    output logic                   lane_ready
);
    import serdes_pkg::*;

    logic [3:0]  rst_sr;
    link_ctrl_t  ctrl_q;
    logic        setup;
    logic        access;
    logic        addr_hit;
    logic [31:0] rd_mux;
    logic [31:0] prdata_q;
    logic        pslverr_q;

    // ########################################
    // lane reset stretcher
    // ########################################

    // ones drain out of the bottom one per cycle after RST drops
    always_ff @(posedge CLKDIV) begin
        if (RST) begin
            rst_sr <= 4'hF;
        end else begin
            rst_sr <= rst_sr >> 1;
        end
    end

    assign lane_rst   = rst_sr[0];
    assign lane_ready = ~rst_sr[0];

    // ########################################
    // APB decode
    // ########################################

    assign setup  = apb_req.psel & ~apb_req.penable;
    assign access = apb_req.psel & apb_req.penable;

    always_comb begin
        addr_hit = 1'b1;
        rd_mux   = '0;
        case (apb_req.paddr)
            `SERDES_ADDR_CTRL:    rd_mux = {31'b0, ctrl_q.enable};
            `SERDES_ADDR_STATUS:  rd_mux = {30'b0, lane_ready, link_stat.locked};
            `SERDES_ADDR_ERRCNT:  rd_mux = 32'(link_stat.err_cnt);
            `SERDES_ADDR_SLIPCNT: rd_mux = 32'(link_stat.slip_cnt);
            default:              addr_hit = 1'b0;
        endcase
    end

    always_ff @(posedge CLKDIV) begin
        if (RST) begin
            ctrl_q    <= '0;
            prdata_q  <= '0;
            pslverr_q <= 1'b0;
        end else begin
            // pulse bits live for one cycle only
            ctrl_q.inject_err <= 1'b0;
            ctrl_q.clear_cnt  <= 1'b0;
            if (access && apb_req.pwrite && apb_req.paddr == `SERDES_ADDR_CTRL) begin
                ctrl_q.enable     <= apb_req.pwdata[0];
                ctrl_q.inject_err <= apb_req.pwdata[1];
                ctrl_q.clear_cnt  <= apb_req.pwdata[2];
            end
            // sampled at setup so data and error sit in the access cycle
            prdata_q  <= (setup && !apb_req.pwrite) ? rd_mux : '0;
            pslverr_q <= setup && !addr_hit;
        end
    end

    assign link_ctrl       = ctrl_q;
    assign apb_rsp.prdata  = prdata_q;
    assign apb_rsp.pready  = 1'b1;
    assign apb_rsp.pslverr = pslverr_q;

    // setup is always followed by a completed access
    a_access_ready : assert property (
        @(posedge CLKDIV) disable iff (RST)
        setup |=> (access && apb_rsp.pready)
    );

endmodule

//--- logic/prbs_gen.sv
`timescale 1ns/1ps
`include "serdes_settings.svh"

module prbs_gen (
    input  logic                   CLKDIV,
    input  logic                   RST,
    input  logic                   lane_rst,
    input  serdes_pkg::link_ctrl_t link_ctrl,
    output serdes_pkg::serdes_word_t word,
    output logic                   word_stb
);
    import serdes_pkg::*;

    localparam prbs_state_t SEED = 7'h7F;
    localparam bit_cnt_t    LAST = bit_cnt_t'(`SERDES_WORD_W - 1);

    prbs_state_t  state;
    serdes_word_t nxt;
    bit_cnt_t     pace;
    logic         pend;

    assign nxt = prbs_word(state);

    always_ff @(posedge CLKDIV) begin
        if (RST) begin
            state    <= SEED;
            pace     <= '0;
            word_stb <= 1'b0;
            pend     <= 1'b0;
        end else begin
            word_stb <= 1'b0;
            if (lane_rst || !link_ctrl.enable) begin
                pace <= '0;
            end else begin
                pace <= (pace == LAST) ? '0 : pace + 1'b1;
                if (pace == '0) begin
                    word_stb <= 1'b1;
                    // injected flip only touches the output word
                    word     <= nxt ^ {pend, {(`SERDES_WORD_W - 1){1'b0}}};
                    state    <= prbs_state_t'(nxt);
                    pend     <= 1'b0;
                end
            end
            // a pulse on the load edge waits for the following word
            if (link_ctrl.inject_err) begin
                pend <= 1'b1;
            end
        end
    end

endmodule

//--- logic/lane_serializer.sv
`timescale 1ns/1ps
`include "serdes_settings.svh"

module lane_serializer (
    input  logic                     CLKDIV,
    input  logic                     RST,
    input  serdes_pkg::serdes_word_t word,
    input  logic                     word_stb,
    output logic                     serial_out
);
    import serdes_pkg::*;

    localparam bit_cnt_t LAST = bit_cnt_t'(`SERDES_WORD_W - 1);

    serdes_word_t shreg;
    bit_cnt_t     bits_left;

    // msb goes straight out, the rest waits in shreg
    always_ff @(posedge CLKDIV) begin
        if (word_stb) begin
            shreg <= {word[`SERDES_WORD_W-2:0], 1'b0};
        end else begin
            shreg <= {shreg[`SERDES_WORD_W-2:0], 1'b0};
        end
    end

    always_ff @(posedge CLKDIV) begin
        if (RST) begin
            bits_left  <= '0;
            serial_out <= 1'b0;
        end else if (word_stb) begin
            serial_out <= word[`SERDES_WORD_W-1];
            bits_left  <= LAST;
        end else if (bits_left != '0) begin
            serial_out <= shreg[`SERDES_WORD_W-1];
            bits_left  <= bits_left - 1'b1;
        end else begin
            // idle line
            serial_out <= 1'b0;
        end
    end

    // generator pacing must match the shift length
    a_no_overrun : assert property (
        @(posedge CLKDIV) disable iff (RST)
        word_stb |-> (bits_left == '0)
    );

endmodule

//--- logic/lane_deserializer.sv
`timescale 1ns/1ps
`include "serdes_settings.svh"

module lane_deserializer (
    input  logic                     CLKDIV,
    input  logic                     RST,
    input  logic                     lane_rst,
    input  logic                     serial_in,
    input  logic                     bitslip,
    output serdes_pkg::serdes_word_t word,
    output logic                     word_vld
);
    import serdes_pkg::*;

    localparam bit_cnt_t LAST = bit_cnt_t'(`SERDES_WORD_W - 1);

    serdes_word_t shreg;
    bit_cnt_t     bit_cnt;
    logic         vld_q;

    // ########################################
    // bit capture
    // ########################################

    // newest bit lands in the lsb
    always_ff @(posedge CLKDIV) begin
        shreg <= {shreg[`SERDES_WORD_W-2:0], serial_in};
    end

    // ########################################
    // word framing
    // ########################################

    always_ff @(posedge CLKDIV) begin
        if (RST || lane_rst) begin
            bit_cnt <= '0;
            vld_q   <= 1'b0;
        end else begin
            vld_q <= 1'b0;
            // slip holds the count, one extra bit enters this frame
            if (!bitslip) begin
                vld_q   <= (bit_cnt == LAST);
                bit_cnt <= (bit_cnt == LAST) ? '0 : bit_cnt + 1'b1;
            end
        end
    end

    // shreg holds the full word during the valid cycle
    assign word     = shreg;
    assign word_vld = vld_q;

endmodule

//--- logic/prbs_checker.sv
`timescale 1ns/1ps
`include "serdes_settings.svh"

module prbs_checker (
    input  logic                     CLKDIV,
    input  logic                     RST,
    input  serdes_pkg::serdes_word_t word,
    input  logic                     word_vld,
    input  serdes_pkg::link_ctrl_t   link_ctrl,
    output logic                     bitslip,
    output serdes_pkg::link_stat_t   link_stat
);
    import serdes_pkg::*;

    localparam int GOOD_W = $clog2(`SERDES_LOCK_GOOD + 1);
    localparam int BAD_W  = $clog2(`SERDES_LOCK_BAD + 1);
    localparam int WAIT_W = $clog2(`SERDES_SLIP_WORDS + 1);
    localparam logic [GOOD_W-1:0] GOOD_LAST = GOOD_W'(`SERDES_LOCK_GOOD - 1);
    localparam logic [BAD_W-1:0]  BAD_LAST  = BAD_W'(`SERDES_LOCK_BAD - 1);
    localparam logic [WAIT_W-1:0] SLIP_LAST = WAIT_W'(`SERDES_SLIP_WORDS - 1);

    chk_state_e        state;
    chk_state_e        state_nxt;
    prbs_state_t       pred;
    serdes_word_t      expected;
    logic              match;
    logic              slip_due;
    logic [GOOD_W-1:0] good_cnt;
    logic [BAD_W-1:0]  bad_cnt;
    logic [WAIT_W-1:0] slip_wait;
    serdes_cnt_t       err_cnt;
    serdes_cnt_t       slip_cnt;

    // ########################################
    // lock state machine
    // ########################################

    always_comb begin
        expected  = prbs_word(pred);
        match     = (word == expected);
        state_nxt = state;
        case (state)
            // an all-zero seed would lock onto a dead line
            SEARCH: if (prbs_state_t'(word) != '0) state_nxt = VERIFY;
            VERIFY: begin
                if (!match) begin
                    state_nxt = SEARCH;
                end else if (good_cnt == GOOD_LAST) begin
                    state_nxt = LOCKED;
                end
            end
            LOCKED: if (!match && bad_cnt == BAD_LAST) state_nxt = SEARCH;
            default: state_nxt = SEARCH;
        endcase
        slip_due = (state_nxt != LOCKED) && (slip_wait == SLIP_LAST);
    end

    always_ff @(posedge CLKDIV) begin
        if (RST) begin
            state     <= SEARCH;
            good_cnt  <= '0;
            bad_cnt   <= '0;
            slip_wait <= '0;
            bitslip   <= 1'b0;
            err_cnt   <= '0;
            slip_cnt  <= '0;
        end else begin
            bitslip <= 1'b0;
            if (word_vld) begin
                state <= slip_due ? SEARCH : state_nxt;
                // once seeded the predictor runs on its own output
                pred <= (state == SEARCH) ? prbs_state_t'(word) : prbs_state_t'(expected);
                good_cnt  <= (state == VERIFY && match) ? good_cnt + 1'b1 : '0;
                bad_cnt   <= (state == LOCKED && !match) ? bad_cnt + 1'b1 : '0;
                slip_wait <= (state_nxt == LOCKED || slip_due) ? '0 : slip_wait + 1'b1;
                bitslip   <= slip_due;
                if (slip_due && slip_cnt != '1) begin
                    slip_cnt <= slip_cnt + 1'b1;
                end
                if (state == LOCKED && !match && err_cnt != '1) begin
                    err_cnt <= err_cnt + 1'b1;
                end
            end
            if (link_ctrl.clear_cnt) begin
                err_cnt  <= '0;
                slip_cnt <= '0;
            end
        end
    end

    assign link_stat.locked   = (state == LOCKED);
    assign link_stat.err_cnt  = err_cnt;
    assign link_stat.slip_cnt = slip_cnt;

    // a slip never fires straight out of lock
    a_no_slip_locked : assert property (
        @(posedge CLKDIV) disable iff (RST)
        link_stat.locked |=> !bitslip
    );

endmodule

//--- logic/serdes_link_top.sv
`timescale 1ns/1ps

module serdes_link_top (
    input  logic                 CLKDIV,
    input  logic                 RST,
    input  serdes_pkg::apb_req_t apb_req,
    output serdes_pkg::apb_rsp_t apb_rsp,
    output logic                 serial_out,
    input  logic                 serial_in,
    output logic                 lane_ready
);
    import serdes_pkg::*;

    link_ctrl_t   link_ctrl;
    link_stat_t   link_stat;
    logic         lane_rst;
    serdes_word_t tx_word;
    logic         tx_stb;
    serdes_word_t rx_word;
    logic         rx_vld;
    logic         bitslip;

    serdes_regs u_regs (
        .CLKDIV     (CLKDIV),
        .RST        (RST),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .link_ctrl  (link_ctrl),
        .link_stat  (link_stat),
        .lane_rst   (lane_rst),
        .lane_ready (lane_ready)
    );

    // transmit side
    prbs_gen u_gen (
        .CLKDIV    (CLKDIV),
        .RST       (RST),
        .lane_rst  (lane_rst),
        .link_ctrl (link_ctrl),
        .word      (tx_word),
        .word_stb  (tx_stb)
    );

    lane_serializer u_ser (
        .CLKDIV     (CLKDIV),
        .RST        (RST),
        .word       (tx_word),
        .word_stb   (tx_stb),
        .serial_out (serial_out)
    );

    // receive side
    lane_deserializer u_des (
        .CLKDIV    (CLKDIV),
        .RST       (RST),
        .lane_rst  (lane_rst),
        .serial_in (serial_in),
        .bitslip   (bitslip),
        .word      (rx_word),
        .word_vld  (rx_vld)
    );

    prbs_checker u_chk (
        .CLKDIV    (CLKDIV),
        .RST       (RST),
        .word      (rx_word),
        .word_vld  (rx_vld),
        .link_ctrl (link_ctrl),
        .bitslip   (bitslip),
        .link_stat (link_stat)
    );

endmodule

//--- verification/tb_serdes_link.sv
`timescale 1ns/1ps
`include "serdes_settings.svh"

module tb_serdes_link;
    import serdes_pkg::*;

    localparam int WORD_CYCLES = `SERDES_WORD_W;
    localparam int POLL_LIMIT  = 400;

    logic        CLKDIV = 1'b0;
    logic        RST;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    logic        serial_out;
    logic        serial_in = 1'b0;
    logic        lane_ready;

    // loopback line
    logic [15:0] lb_sr = '0;
    logic [3:0]  lb_delay;
    logic        lb_zero;
    integer      seed;

    // register model
    logic        model_enable;
    logic        model_ready;
    logic        model_locked;
    serdes_cnt_t model_err;
    serdes_cnt_t model_slip;

    int          pass_cnt;
    int          fail_cnt;
    int          n_inject;
    logic [31:0] rdata;
    logic        rerr;

    serdes_link_top u_dut (
        .CLKDIV     (CLKDIV),
        .RST        (RST),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .serial_out (serial_out),
        .serial_in  (serial_in),
        .lane_ready (lane_ready)
    );

    always #2 CLKDIV = ~CLKDIV;

    // serial_out comes back lb_delay+1 bits later
    always @(posedge CLKDIV) begin
        lb_sr     <= {lb_sr[14:0], serial_out};
        serial_in <= lb_zero ? 1'b0 : lb_sr[lb_delay];
    end

    // ########################################
    // reference model
    // ########################################

    function automatic logic [31:0] ref_read(input logic [7:0] addr);
        logic [31:0] v;
        case (addr)
            `SERDES_ADDR_CTRL:    v = {31'b0, model_enable};
            `SERDES_ADDR_STATUS:  v = {30'b0, model_ready, model_locked};
            `SERDES_ADDR_ERRCNT:  v = {16'b0, model_err};
            `SERDES_ADDR_SLIPCNT: v = {16'b0, model_slip};
            default:              v = '0;
        endcase
        return v;
    endfunction

    function automatic logic ref_slverr(input logic [7:0] addr);
        return !(addr inside {`SERDES_ADDR_CTRL, `SERDES_ADDR_STATUS,
                              `SERDES_ADDR_ERRCNT, `SERDES_ADDR_SLIPCNT});
    endfunction

    // only CTRL writes change anything
    task automatic apply_write(input logic [7:0] addr, input logic [31:0] data);
        if (addr == `SERDES_ADDR_CTRL) begin
            model_enable = data[0];
            // an injected flip only counts once the checker is locked
            if (data[1] && model_locked) model_err++;
            if (data[2]) begin
                model_err  = '0;
                model_slip = '0;
            end
        end
    endtask

    // ########################################
    // compare tasks
    // ########################################

    task automatic check_reg(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp === act) begin
            $display("ok   %s = 0x%08h", name, act);
            pass_cnt++;
        end else begin
            $display("CHECK FAILED %s: expected 0x%08h, actual 0x%08h", name, exp, act);
            fail_cnt++;
        end
    endtask

    task automatic check_cnt(input string name, input serdes_cnt_t exp, input serdes_cnt_t act);
        if (exp === act) begin
            $display("ok   %s = %0d", name, act);
            pass_cnt++;
        end else begin
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
            fail_cnt++;
        end
    endtask

    task automatic check_resp(input string name, input logic exp, input logic act);
        if (exp === act) begin
            $display("ok   %s pslverr = %0b", name, act);
            pass_cnt++;
        end else begin
            $display("CHECK FAILED %s pslverr: expected %0b, actual %0b", name, exp, act);
            fail_cnt++;
        end
    endtask

    // ########################################
    // APB driver
    // ########################################

    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] data, output logic slverr);
        apb_req_t req;
        int       waits;
        req        = '0;
        req.psel   = 1'b1;
        req.pwrite = wr;
        req.paddr  = addr;
        req.pwdata = wdata;
        waits      = 0;
        @(posedge CLKDIV);
        apb_req <= req;
        @(posedge CLKDIV);
        apb_req.penable <= 1'b1;
        @(negedge CLKDIV);
        while (!apb_rsp.pready && waits < POLL_LIMIT) begin
            @(negedge CLKDIV);
            waits++;
        end
        if (!apb_rsp.pready) begin
            $display("APB access to 0x%02h never saw pready", addr);
            fail_cnt++;
        end
        data   = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        @(posedge CLKDIV);
        apb_req <= '0;
    endtask

    task automatic apb_write(input string name, input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] d;
        logic        e;
        apb_xfer(1'b1, addr, data, d, e);
        apply_write(addr, data);
        check_resp(name, ref_slverr(addr), e);
    endtask

    task automatic read_reg(input string name, input logic [7:0] addr);
        logic [31:0] d;
        logic        e;
        apb_xfer(1'b0, addr, '0, d, e);
        check_reg(name, ref_read(addr), d);
        check_resp(name, ref_slverr(addr), e);
    endtask

    task automatic read_cnt(input string name, input logic [7:0] addr);
        logic [31:0] d;
        logic [31:0] exp;
        logic        e;
        apb_xfer(1'b0, addr, '0, d, e);
        exp = ref_read(addr);
        check_cnt(name, exp[15:0], d[15:0]);
    endtask

    // ########################################
    // polling waits
    // ########################################

    task automatic wait_lane_ready();
        int n;
        n = 0;
        @(negedge CLKDIV);
        while (lane_ready !== 1'b1 && n < POLL_LIMIT) begin
            @(negedge CLKDIV);
            n++;
        end
        if (lane_ready !== 1'b1) begin
            $display("timeout: lane_ready never went high after reset");
            fail_cnt++;
        end
    endtask

    task automatic wait_locked(input logic want, input string what);
        int n;
        n = 0;
        apb_xfer(1'b0, `SERDES_ADDR_STATUS, '0, rdata, rerr);
        while (rdata[0] !== want && n < POLL_LIMIT) begin
            apb_xfer(1'b0, `SERDES_ADDR_STATUS, '0, rdata, rerr);
            n++;
        end
        if (rdata[0] !== want) begin
            $display("timeout: %s, the locked bit never became %0b", what, want);
            fail_cnt++;
        end
    endtask

    task automatic wait_errcnt(input serdes_cnt_t target);
        int n;
        n = 0;
        apb_xfer(1'b0, `SERDES_ADDR_ERRCNT, '0, rdata, rerr);
        while (rdata[15:0] !== target && n < POLL_LIMIT) begin
            apb_xfer(1'b0, `SERDES_ADDR_ERRCNT, '0, rdata, rerr);
            n++;
        end
        if (rdata[15:0] !== target) begin
            $display("timeout: error count never reached %0d", target);
            fail_cnt++;
        end
    endtask

    // ########################################
    // test sequence
    // ########################################

    initial begin
        seed         = 36350;
        RST          = 1'b1;
        apb_req      = '0;
        lb_zero      = 1'b0;
        lb_delay     = 4'($random(seed));
        n_inject     = 2 + ($random(seed) & 3);
        model_enable = 1'b0;
        model_ready  = 1'b0;
        model_locked = 1'b0;
        model_err    = '0;
        model_slip   = '0;
        pass_cnt     = 0;
        fail_cnt     = 0;
        $display("loopback delay %0d bits, %0d injected errors", int'(lb_delay) + 1, n_inject);
        repeat (4) @(posedge CLKDIV);
        RST <= 1'b0;

        // registers out of reset, lane still held
        read_reg("reset STATUS", `SERDES_ADDR_STATUS);
        read_reg("reset CTRL", `SERDES_ADDR_CTRL);
        read_reg("reset ERRCNT", `SERDES_ADDR_ERRCNT);
        read_reg("reset SLIPCNT", `SERDES_ADDR_SLIPCNT);
        wait_lane_ready();
        model_ready = 1'b1;
        read_reg("STATUS lane ready", `SERDES_ADDR_STATUS);
        apb_write("CTRL write all bits", `SERDES_ADDR_CTRL, 32'h7);
        read_reg("CTRL readback enabled", `SERDES_ADDR_CTRL);
        apb_write("CTRL write zero", `SERDES_ADDR_CTRL, 32'h0);
        read_reg("CTRL readback disabled", `SERDES_ADDR_CTRL);

        // lock through the loopback
        apb_write("CTRL enable", `SERDES_ADDR_CTRL, 32'h1);
        wait_locked(1'b1, "initial lock");
        model_locked = 1'b1;
        read_reg("STATUS locked", `SERDES_ADDR_STATUS);
        repeat (50 * WORD_CYCLES) @(posedge CLKDIV);
        read_cnt("ERRCNT after 50 words", `SERDES_ADDR_ERRCNT);

        // single-bit errors, each one seen before the next
        for (int i = 0; i < n_inject; i++) begin
            apb_write("CTRL inject", `SERDES_ADDR_CTRL, 32'h3);
            wait_errcnt(model_err);
        end
        read_cnt("ERRCNT after inject", `SERDES_ADDR_ERRCNT);
        read_reg("STATUS after inject", `SERDES_ADDR_STATUS);

        // unmapped addresses
        read_reg("read unmapped 0x10", 8'h10);
        apb_write("write unmapped 0x10", 8'h10, 32'h0);
        apb_write("write unmapped 0x06", 8'h06, 32'h0);
        read_reg("CTRL after unmapped", `SERDES_ADDR_CTRL);
        read_cnt("ERRCNT after unmapped", `SERDES_ADDR_ERRCNT);

        // dead line drops lock after the bad-word run
        @(posedge CLKDIV);
        lb_zero <= 1'b1;
        wait_locked(1'b0, "lock loss on a dead line");
        model_locked = 1'b0;
        model_err    = model_err + serdes_cnt_t'(`SERDES_LOCK_BAD);
        read_cnt("ERRCNT after lock loss", `SERDES_ADDR_ERRCNT);
        read_reg("STATUS unlocked", `SERDES_ADDR_STATUS);
        // stay dead long enough for at least one bitslip
        repeat (`SERDES_SLIP_WORDS * WORD_CYCLES) @(posedge CLKDIV);
        @(posedge CLKDIV);
        lb_zero <= 1'b0;
        wait_locked(1'b1, "relock after restore");
        model_locked = 1'b1;
        read_reg("STATUS relocked", `SERDES_ADDR_STATUS);

        // both counters hold nonzero values here
        apb_write("CTRL clear", `SERDES_ADDR_CTRL, 32'h5);
        read_cnt("ERRCNT after clear", `SERDES_ADDR_ERRCNT);
        read_cnt("SLIPCNT after clear", `SERDES_ADDR_SLIPCNT);

        $display("checks: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+include
logic/serdes_pkg.sv
logic/serdes_regs.sv
logic/prbs_gen.sv
logic/lane_serializer.sv
logic/lane_deserializer.sv
logic/prbs_checker.sv
logic/serdes_link_top.sv
verification/tb_serdes_link.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_serdes_link
FILELIST  = src.f
OBJDIR    = obj_dir
LOG       = sim.log

SRCS = $(filter-out +%,$(shell cat $(FILELIST)))
HDRS = $(wildcard include/*.svh)
BIN  = $(OBJDIR)/V$(TOP)

.PHONY: all run check-log clean

all: run

$(BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	grep -qx 'Test passed' $(LOG)

check-log:
	grep -qx 'Test passed' $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
